// File: hw/ps2_line_pkg.sv
package ps2_line_pkg;

  // Frame layout: start, 8 data bits LSB first, odd parity, stop
  localparam int FRAME_BITS = 11;
  localparam int BIT_CNT_W  = 4;    // Holds 0..FRAME_BITS

  // Idle watchdog, sized for a 10 MHz system clock
  localparam int CLKS_PER_60US = 600;
  localparam int WDOG_W        = 10;  // 2**10 > CLKS_PER_60US

  // Receiver states
  // The two MARK states last one cycle and act as edge strobes
  typedef enum logic [1:0] {
    LINE_CLK_LOW  = 2'd0,  // Keyboard clock low, waiting for rise
    LINE_CLK_HIGH = 2'd1,  // Keyboard clock high, waiting for fall
    FALL_MARK     = 2'd2,  // Falling edge seen, sample data here
    RISE_MARK     = 2'd3   // Rising edge seen
  } frame_state_t;

endpackage

// File: hw/ps2_key_pkg.sv
package ps2_key_pkg;

  localparam int SCAN_W = 8;

  // Prefix and modifier scan codes (set 2)
  localparam logic [SCAN_W-1:0] CODE_EXTEND  = 8'hE0;
  localparam logic [SCAN_W-1:0] CODE_RELEASE = 8'hF0;
  localparam logic [SCAN_W-1:0] CODE_LSHIFT  = 8'h12;
  localparam logic [SCAN_W-1:0] CODE_RSHIFT  = 8'h59;

  // Control keys, shift independent
  localparam logic [SCAN_W-1:0] CODE_BKSP   = 8'h66;
  localparam logic [SCAN_W-1:0] CODE_TAB    = 8'h0D;
  localparam logic [SCAN_W-1:0] CODE_ENTER  = 8'h5A;
  localparam logic [SCAN_W-1:0] CODE_ESC    = 8'h76;
  localparam logic [SCAN_W-1:0] CODE_SPACE  = 8'h29;
  localparam logic [SCAN_W-1:0] CODE_DELETE = 8'h71;  // Also keypad dot

  // ASCII results
  localparam logic [7:0] ASCII_UNKNOWN = 8'h2E;  // '.' for unlisted codes
  localparam logic [7:0] ASCII_BS      = 8'h08;
  localparam logic [7:0] ASCII_TAB     = 8'h09;
  localparam logic [7:0] ASCII_CR      = 8'h0D;
  localparam logic [7:0] ASCII_ESC     = 8'h1B;
  localparam logic [7:0] ASCII_SPACE   = 8'h20;
  localparam logic [7:0] ASCII_DEL     = 8'h7F;

  // Classification of a received code inside the tracker
  typedef enum logic [1:0] {
    KIND_KEY     = 2'd0,
    KIND_EXTEND  = 2'd1,
    KIND_RELEASE = 2'd2
  } code_kind_t;

  // Host side data-ready FSM
  typedef enum logic {
    RDY_IDLE = 1'b0,
    RDY_FULL = 1'b1
  } ready_state_t;

endpackage

// File: hw/ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           ps2_clk_i,
  input  logic                           ps2_data_i,
  output logic [ps2_key_pkg::SCAN_W-1:0] code_o,
  output logic                           code_valid_o
);
  import ps2_line_pkg::*;
  import ps2_key_pkg::*;

  logic clk_meta;   // First sync stage
  logic clk_sync;
  logic data_meta;
  logic data_sync;

  frame_state_t state_q;
  frame_state_t state_d;

  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [FRAME_BITS-1:0] shift_q;   // Bit 0 ends up holding the start bit
  logic [WDOG_W-1:0]     wdog_cnt;

  logic wdog_done;
  logic idle_timeout;
  logic frame_done;

  // Two-flop synchronizers
  // Preset to the idle-high level so reset does not look like a falling edge
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_meta  <= 1'b1;
      clk_sync  <= 1'b1;
      data_meta <= 1'b1;
      data_sync <= 1'b1;
    end
    else
    begin
      clk_meta  <= ps2_clk_i;
      clk_sync  <= clk_meta;
      data_meta <= ps2_data_i;
      data_sync <= data_meta;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state_q <= LINE_CLK_HIGH;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      LINE_CLK_HIGH: if (!clk_sync) state_d = FALL_MARK;
      FALL_MARK:     state_d = LINE_CLK_LOW;     // One-cycle strobe
      LINE_CLK_LOW:  if (clk_sync) state_d = RISE_MARK;
      RISE_MARK:     state_d = LINE_CLK_HIGH;
      default:       state_d = LINE_CLK_HIGH;
    endcase
  end

  // Idle watchdog, counts only while the line sits high
  always_ff @(posedge clk)
  begin
    if (reset || (state_q != LINE_CLK_HIGH) || !clk_sync)
      wdog_cnt <= '0;
    else if (!wdog_done)
      wdog_cnt <= wdog_cnt + 1'b1;  // Saturates at terminal count
  end

  assign wdog_done    = (wdog_cnt == WDOG_W'(CLKS_PER_60US - 1));
  assign idle_timeout = wdog_done && (state_q == LINE_CLK_HIGH) && clk_sync;
  assign frame_done   = (bit_cnt == BIT_CNT_W'(FRAME_BITS));

  // Bit counter
  always_ff @(posedge clk)
  begin
    if (reset || frame_done || idle_timeout)
      bit_cnt <= '0;               // Frame complete or partial frame dropped
    else if (state_q == FALL_MARK)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // Data shifts in LSB first, so the newest bit enters at the top
  always_ff @(posedge clk)
  begin
    if (reset)
      shift_q <= '0;
    else if (state_q == FALL_MARK)
      shift_q <= {data_sync, shift_q[FRAME_BITS-1:1]};
  end

  // Parity and stop bits are carried but not checked
  assign code_o       = shift_q[SCAN_W:1];
  assign code_valid_o = frame_done;   // High for the one cycle before the clear

endmodule

// File: hw/ps2_code_tracker.sv
`timescale 1ns/1ps

module ps2_code_tracker (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [ps2_key_pkg::SCAN_W-1:0] code_i,
  input  logic                           code_valid_i,
  output logic [ps2_key_pkg::SCAN_W-1:0] key_code_o,
  output logic                           key_extended_o,
  output logic                           key_released_o,
  output logic                           shift_on_o,
  output logic                           key_valid_o
);
  import ps2_key_pkg::*;

  code_kind_t kind;

  logic hold_ext;    // E0 seen, waiting for the key code
  logic hold_rel;    // F0 seen
  logic lshift_q;
  logic rshift_q;

  always_comb
  begin
    if (code_i == CODE_EXTEND)
      kind = KIND_EXTEND;
    else if (code_i == CODE_RELEASE)
      kind = KIND_RELEASE;
    else
      kind = KIND_KEY;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hold_ext       <= 1'b0;
      hold_rel       <= 1'b0;
      lshift_q       <= 1'b0;
      rshift_q       <= 1'b0;
      key_code_o     <= '0;
      key_extended_o <= 1'b0;
      key_released_o <= 1'b0;
      shift_on_o     <= 1'b0;
      key_valid_o    <= 1'b0;
    end
    else
    begin
      key_valid_o <= 1'b0;   // Pulse by default
      if (code_valid_i)
      begin
        case (kind)
          KIND_EXTEND:  hold_ext <= 1'b1;   // Prefix only, no event
          KIND_RELEASE: hold_rel <= 1'b1;
          default:
          begin
            key_code_o     <= code_i;
            key_extended_o <= hold_ext;
            key_released_o <= hold_rel;
            shift_on_o     <= lshift_q | rshift_q;  // State before this key
            key_valid_o    <= 1'b1;
            hold_ext       <= 1'b0;
            hold_rel       <= 1'b0;
            // Make code sets, break code clears
            if (code_i == CODE_LSHIFT)
              lshift_q <= ~hold_rel;
            if (code_i == CODE_RSHIFT)
              rshift_q <= ~hold_rel;
          end
        endcase
      end
    end
  end

endmodule

// File: hw/ps2_ascii_stage.sv
`timescale 1ns/1ps

module ps2_ascii_stage (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [ps2_key_pkg::SCAN_W-1:0] key_code_i,
  input  logic                           key_extended_i,
  input  logic                           key_released_i,
  input  logic                           shift_on_i,
  input  logic                           key_valid_i,
  input  logic                           rx_read_i,
  output logic [ps2_key_pkg::SCAN_W-1:0] rx_scan_code_o,
  output logic [7:0]                     rx_ascii_o,
  output logic                           rx_extended_o,
  output logic                           rx_released_o,
  output logic                           rx_shift_key_on_o,
  output logic                           rx_data_ready_o
);
  import ps2_key_pkg::*;

  ready_state_t rdy_q;
  ready_state_t rdy_d;

  logic [7:0] ascii_c;

  // Reduced lookup: letters, digits and a few control keys
  always_comb
  begin
    ascii_c = ASCII_UNKNOWN;
    case (key_code_i)
      CODE_BKSP:   ascii_c = ASCII_BS;
      CODE_TAB:    ascii_c = ASCII_TAB;
      CODE_ENTER:  ascii_c = ASCII_CR;
      CODE_ESC:    ascii_c = ASCII_ESC;
      CODE_SPACE:  ascii_c = ASCII_SPACE;
      CODE_DELETE: ascii_c = ASCII_DEL;
      // Digit row, shifted symbols as on a US layout
      8'h16: ascii_c = shift_on_i ? 8'h21 : 8'h31;  // 1 !
      8'h1E: ascii_c = shift_on_i ? 8'h40 : 8'h32;  // 2 @
      8'h26: ascii_c = shift_on_i ? 8'h23 : 8'h33;  // 3 #
      8'h25: ascii_c = shift_on_i ? 8'h24 : 8'h34;  // 4 $
      8'h2E: ascii_c = shift_on_i ? 8'h25 : 8'h35;  // 5 %
      8'h36: ascii_c = shift_on_i ? 8'h5E : 8'h36;  // 6 ^
      8'h3D: ascii_c = shift_on_i ? 8'h26 : 8'h37;  // 7 &
      8'h3E: ascii_c = shift_on_i ? 8'h2A : 8'h38;  // 8 *
      8'h46: ascii_c = shift_on_i ? 8'h28 : 8'h39;  // 9 (
      8'h45: ascii_c = shift_on_i ? 8'h29 : 8'h30;  // 0 )
      // Letters
      8'h1C: ascii_c = shift_on_i ? 8'h41 : 8'h61;  // a
      8'h32: ascii_c = shift_on_i ? 8'h42 : 8'h62;  // b
      8'h21: ascii_c = shift_on_i ? 8'h43 : 8'h63;  // c
      8'h23: ascii_c = shift_on_i ? 8'h44 : 8'h64;  // d
      8'h24: ascii_c = shift_on_i ? 8'h45 : 8'h65;  // e
      8'h2B: ascii_c = shift_on_i ? 8'h46 : 8'h66;  // f
      8'h34: ascii_c = shift_on_i ? 8'h47 : 8'h67;  // g
      8'h33: ascii_c = shift_on_i ? 8'h48 : 8'h68;  // h
      8'h43: ascii_c = shift_on_i ? 8'h49 : 8'h69;  // i
      8'h3B: ascii_c = shift_on_i ? 8'h4A : 8'h6A;  // j
      8'h42: ascii_c = shift_on_i ? 8'h4B : 8'h6B;  // k
      8'h4B: ascii_c = shift_on_i ? 8'h4C : 8'h6C;  // l
      8'h3A: ascii_c = shift_on_i ? 8'h4D : 8'h6D;  // m
      8'h31: ascii_c = shift_on_i ? 8'h4E : 8'h6E;  // n
      8'h44: ascii_c = shift_on_i ? 8'h4F : 8'h6F;  // o
      8'h4D: ascii_c = shift_on_i ? 8'h50 : 8'h70;  // p
      8'h15: ascii_c = shift_on_i ? 8'h51 : 8'h71;  // q
      8'h2D: ascii_c = shift_on_i ? 8'h52 : 8'h72;  // r
      8'h1B: ascii_c = shift_on_i ? 8'h53 : 8'h73;  // s
      8'h2C: ascii_c = shift_on_i ? 8'h54 : 8'h74;  // t
      8'h3C: ascii_c = shift_on_i ? 8'h55 : 8'h75;  // u
      8'h2A: ascii_c = shift_on_i ? 8'h56 : 8'h76;  // v
      8'h1D: ascii_c = shift_on_i ? 8'h57 : 8'h77;  // w
      8'h22: ascii_c = shift_on_i ? 8'h58 : 8'h78;  // x
      8'h35: ascii_c = shift_on_i ? 8'h59 : 8'h79;  // y
      8'h1A: ascii_c = shift_on_i ? 8'h5A : 8'h7A;  // z
      default: ascii_c = ASCII_UNKNOWN;
    endcase
  end

  // Output registers, overwritten by every new key
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_scan_code_o    <= '0;
      rx_ascii_o        <= '0;
      rx_extended_o     <= 1'b0;
      rx_released_o     <= 1'b0;
      rx_shift_key_on_o <= 1'b0;
    end
    else if (key_valid_i)
    begin
      rx_scan_code_o    <= key_code_i;
      rx_ascii_o        <= ascii_c;
      rx_extended_o     <= key_extended_i;
      rx_released_o     <= key_released_i;
      rx_shift_key_on_o <= shift_on_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      rdy_q <= RDY_IDLE;
    else
      rdy_q <= rdy_d;
  end

  // A key arriving in the same cycle as a read wins, ready stays up
  always_comb
  begin
    rdy_d = rdy_q;
    case (rdy_q)
      RDY_IDLE: if (key_valid_i) rdy_d = RDY_FULL;
      RDY_FULL: if (rx_read_i && !key_valid_i) rdy_d = RDY_IDLE;
      default:  rdy_d = RDY_IDLE;
    endcase
  end

  assign rx_data_ready_o = (rdy_q == RDY_FULL);

endmodule

// File: hw/ps2_keyboard.sv
`timescale 1ns/1ps

module ps2_keyboard (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           ps2_clk_i,
  input  logic                           ps2_data_i,
  input  logic                           rx_read_i,
  output logic [ps2_key_pkg::SCAN_W-1:0] rx_scan_code_o,
  output logic [7:0]                     rx_ascii_o,
  output logic                           rx_extended_o,
  output logic                           rx_released_o,
  output logic                           rx_shift_key_on_o,
  output logic                           rx_data_ready_o
);
  import ps2_key_pkg::*;

  // Frame receiver to tracker
  logic [SCAN_W-1:0] code;
  logic              code_valid;

  // Tracker to ASCII stage
  logic [SCAN_W-1:0] key_code;
  logic              key_extended;
  logic              key_released;
  logic              shift_on;
  logic              key_valid;

  ps2_frame_rx u_frame_rx (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk_i    (ps2_clk_i),
    .ps2_data_i   (ps2_data_i),
    .code_o       (code),
    .code_valid_o (code_valid)
  );

  ps2_code_tracker u_code_tracker (
    .clk            (clk),
    .reset          (reset),
    .code_i         (code),
    .code_valid_i   (code_valid),
    .key_code_o     (key_code),
    .key_extended_o (key_extended),
    .key_released_o (key_released),
    .shift_on_o     (shift_on),
    .key_valid_o    (key_valid)
  );

  ps2_ascii_stage u_ascii_stage (
    .clk               (clk),
    .reset             (reset),
    .key_code_i        (key_code),
    .key_extended_i    (key_extended),
    .key_released_i    (key_released),
    .shift_on_i        (shift_on),
    .key_valid_i       (key_valid),
    .rx_read_i         (rx_read_i),
    .rx_scan_code_o    (rx_scan_code_o),
    .rx_ascii_o        (rx_ascii_o),
    .rx_extended_o     (rx_extended_o),
    .rx_released_o     (rx_released_o),
    .rx_shift_key_on_o (rx_shift_key_on_o),
    .rx_data_ready_o   (rx_data_ready_o)
  );

endmodule

// File: tb/ps2_keyboard_props.sv
`timescale 1ns/1ps

module ps2_keyboard_props (
  input logic                           clk,
  input logic                           reset,
  input logic                           rx_read_i,
  input logic                           rx_data_ready_o,
  input logic                           code_valid_i,
  input logic                           key_valid_i,
  input logic [ps2_key_pkg::SCAN_W-1:0] key_code_i
);
  import ps2_key_pkg::*;

  // Read while full empties the output, unless a new key lands in that cycle
  read_clears_ready: assert property (@(posedge clk) disable iff (reset)
    (rx_read_i && rx_data_ready_o && !key_valid_i) |=> !rx_data_ready_o)
    else $error("data ready still high after a read");

  code_valid_pulse: assert property (@(posedge clk) disable iff (reset)
    code_valid_i |=> !code_valid_i)
    else $error("code valid lasted two cycles");

  key_valid_pulse: assert property (@(posedge clk) disable iff (reset)
    key_valid_i |=> !key_valid_i)
    else $error("key valid lasted two cycles");

  // Prefixes are absorbed by the tracker
  no_prefix_event: assert property (@(posedge clk) disable iff (reset)
    key_valid_i |-> (key_code_i != CODE_EXTEND && key_code_i != CODE_RELEASE))
    else $error("key event carried a prefix code");

endmodule

bind ps2_keyboard ps2_keyboard_props u_props (
  .clk             (clk),
  .reset           (reset),
  .rx_read_i       (rx_read_i),
  .rx_data_ready_o (rx_data_ready_o),
  .code_valid_i    (code_valid),
  .key_valid_i     (key_valid),
  .key_code_i      (key_code)
);

// File: tb/ps2_keyboard_tb.sv
`timescale 1ns/1ps

module ps2_keyboard_tb;
  import ps2_line_pkg::*;

  localparam int HALF_CLKS     = 400;   // 40 us keyboard half period at 10 MHz
  localparam int GAP_CLKS      = 1000;  // Idle between frames
  localparam int LONG_IDLE     = 700;   // 70 us, past the receiver's 60 us limit
  localparam int READY_TIMEOUT = 2000;
  localparam int RAND_KEYS     = 20;
  localparam int NUM_FRAMES    = 1 + 5 + 3 + 2 + RAND_KEYS * 4;  // Worst case with shift
  localparam int WATCHDOG_NS   = NUM_FRAMES * 1_000_000 + 2_000_000;

  // Set 2 make codes, a..z and 1..0
  localparam logic [7:0] LETTER_CODES [0:25] = '{
    8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A,
    8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
  localparam logic [7:0] DIGIT_CODES [0:9] = '{
    8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45};

  logic       clk;
  logic       reset;
  logic       ps2_clk;
  logic       ps2_data;
  logic       rx_read;
  logic [7:0] rx_scan_code;
  logic [7:0] rx_ascii;
  logic       rx_extended;
  logic       rx_released;
  logic       rx_shift_key_on;
  logic       rx_data_ready;

  int value_errs = 0;
  int other_errs = 0;

  ps2_keyboard UUT (
    .clk               (clk),
    .reset             (reset),
    .ps2_clk_i         (ps2_clk),
    .ps2_data_i        (ps2_data),
    .rx_read_i         (rx_read),
    .rx_scan_code_o    (rx_scan_code),
    .rx_ascii_o        (rx_ascii),
    .rx_extended_o     (rx_extended),
    .rx_released_o     (rx_released),
    .rx_shift_key_on_o (rx_shift_key_on),
    .rx_data_ready_o   (rx_data_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 10 MHz
  end

  // Hard stop in case the DUT or a task hangs
  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [7:0] exp, input logic [7:0] act);
    $display("ERR %s %s expected %02h actual %02h", name, field, exp, act);
    value_errs++;
  endtask

  // Start 0, data LSB first, odd parity, stop 1
  function automatic logic [FRAME_BITS-1:0] build_frame(input logic [7:0] code);
    return {1'b1, ~^code, code, 1'b0};
  endfunction

  // ASCII rules: letters, digits with US shift symbols, control keys, else '.'
  function automatic logic [7:0] expected_ascii(input logic [7:0] code, input logic shift);
    string      digits;
    string      symbols;
    logic [7:0] result;
    int         i;
    digits  = "1234567890";
    symbols = "!@#$%^&*()";
    result  = 8'h2E;
    for (i = 0; i < 26; i++)
      if (LETTER_CODES[i] == code)
        result = shift ? 8'h41 + 8'(i) : 8'h61 + 8'(i);
    for (i = 0; i < 10; i++)
      if (DIGIT_CODES[i] == code)
        result = shift ? symbols[i] : digits[i];
    case (code)
      8'h29: result = 8'h20;  // Space
      8'h5A: result = 8'h0D;  // Enter
      8'h66: result = 8'h08;  // Backspace
      8'h0D: result = 8'h09;  // Tab
      8'h76: result = 8'h1B;  // Escape
      8'h71: result = 8'h7F;  // Delete
      default: ;
    endcase
    return result;
  endfunction

  // Data changes while the keyboard clock is high
  task automatic send_bits(input logic [FRAME_BITS-1:0] frame, input int nbits);
    int i;
    for (i = 0; i < nbits; i++)
    begin
      ps2_data = frame[i];
      wait_clks(HALF_CLKS);
      ps2_clk = 1'b0;          // DUT samples on this fall
      wait_clks(HALF_CLKS);
      ps2_clk = 1'b1;
    end
  endtask

  task automatic send_frame(input logic [7:0] code);
    send_bits(build_frame(code), FRAME_BITS);
    wait_clks(GAP_CLKS);
  endtask

  task automatic read_key(input string name, input logic [7:0] exp_scan,
                          input logic [7:0] exp_ascii, input logic exp_ext,
                          input logic exp_rel, input logic exp_shift);
    int waited;
    waited = 0;
    while (rx_data_ready !== 1'b1 && waited < READY_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (waited >= READY_TIMEOUT)
    begin
      $display("%s: data ready never went high", name);
      other_errs++;
    end
    else
    begin
      if (rx_scan_code !== exp_scan)
        report_mismatch(name, "scan", exp_scan, rx_scan_code);
      if (rx_ascii !== exp_ascii)
        report_mismatch(name, "ascii", exp_ascii, rx_ascii);
      if (rx_extended !== exp_ext)
        report_mismatch(name, "extended", 8'(exp_ext), 8'(rx_extended));
      if (rx_released !== exp_rel)
        report_mismatch(name, "released", 8'(exp_rel), 8'(rx_released));
      if (rx_shift_key_on !== exp_shift)
        report_mismatch(name, "shift", 8'(exp_shift), 8'(rx_shift_key_on));
      rx_read = 1'b1;
      @(negedge clk);
      rx_read = 1'b0;
      if (rx_data_ready !== 1'b0)
      begin
        $display("%s: data ready stayed high after the read", name);
        other_errs++;
      end
    end
  endtask

  task automatic test_reset_values();
    if (rx_data_ready !== 1'b0)
      report_mismatch("reset", "ready", 8'h00, 8'(rx_data_ready));
    if (rx_scan_code !== 8'h00)
      report_mismatch("reset", "scan", 8'h00, rx_scan_code);
    if (rx_ascii !== 8'h00)
      report_mismatch("reset", "ascii", 8'h00, rx_ascii);
    if ({rx_extended, rx_released, rx_shift_key_on} !== 3'b000)
      report_mismatch("reset", "flags", 8'h00, 8'({rx_extended, rx_released, rx_shift_key_on}));
  endtask

  task automatic test_single_key();
    send_frame(8'h1C);
    read_key("single_a", 8'h1C, 8'h61, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_shift_sequence();
    send_frame(8'h12);
    read_key("shift_press", 8'h12, 8'h2E, 1'b0, 1'b0, 1'b0);
    send_frame(8'h1C);
    read_key("shifted_a", 8'h1C, 8'h41, 1'b0, 1'b0, 1'b1);
    send_frame(8'hF0);
    send_frame(8'h12);
    read_key("shift_release", 8'h12, 8'h2E, 1'b0, 1'b1, 1'b1);  // Shift state before release
    send_frame(8'h16);
    read_key("digit_1", 8'h16, 8'h31, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_extended_release();
    send_frame(8'hE0);
    send_frame(8'hF0);
    if (rx_data_ready !== 1'b0)
    begin
      $display("ext_release: a prefix code raised data ready");
      other_errs++;
    end
    send_frame(8'h71);
    read_key("ext_release", 8'h71, 8'h7F, 1'b1, 1'b1, 1'b0);
  endtask

  // Five bits then silence, the receiver must drop them
  task automatic test_watchdog_recovery();
    send_bits(build_frame(8'h1C), 5);
    wait_clks(LONG_IDLE);
    send_frame(8'h29);
    read_key("after_partial", 8'h29, 8'h20, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_random_keys();
    int         n;
    int         idx;
    logic       shift;
    logic [7:0] code;
    string      name;
    for (n = 0; n < RAND_KEYS; n++)
    begin
      idx   = $urandom % 36;
      shift = ($urandom % 2) == 1;
      code  = (idx < 26) ? LETTER_CODES[idx] : DIGIT_CODES[idx - 26];
      name  = $sformatf("random_%0d", n);
      if (shift)
      begin
        send_frame(8'h12);
        read_key({name, "_press"}, 8'h12, 8'h2E, 1'b0, 1'b0, 1'b0);
      end
      send_frame(code);
      read_key(name, code, expected_ascii(code, shift), 1'b0, 1'b0, shift);
      if (shift)
      begin
        send_frame(8'hF0);
        send_frame(8'h12);
        read_key({name, "_release"}, 8'h12, 8'h2E, 1'b0, 1'b1, 1'b1);
      end
    end
  endtask

  initial
  begin
    void'($urandom(32'h90f3));
    reset    = 1'b1;
    ps2_clk  = 1'b1;   // Idle bus
    ps2_data = 1'b1;
    rx_read  = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    test_reset_values();
    test_single_key();
    test_shift_sequence();
    test_extended_release();
    test_watchdog_recovery();
    test_random_keys();
    $display("Error counts: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: compile.f
hw/ps2_line_pkg.sv
hw/ps2_key_pkg.sv
hw/ps2_frame_rx.sv
hw/ps2_code_tracker.sv
hw/ps2_ascii_stage.sv
hw/ps2_keyboard.sv
tb/ps2_keyboard_props.sv
tb/ps2_keyboard_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the PS/2 keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f \
  --top-module ps2_keyboard_tb -Mdir obj_dir -o sim_ps2_keyboard
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ps2_keyboard > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
exit 0
